//--- design/board_params.svh
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// ------------------------------
// Board I/O widths
// ------------------------------

`define W_KEY            4                        // Push buttons
`define W_SW             18                       // Slide switches, top one is reset
`define W_LED            18                       // Red LEDs
`define W_DIGIT          8                        // Seven-segment digits

// ------------------------------
// Clocking
// ------------------------------

`define CLK_MHZ          50                       // Board oscillator
`define SLOW_TICK_CYCLES (`CLK_MHZ * 1_000_000)   // One counter step per second
`define SCAN_CYCLES      1024                     // Dwell time per digit

// ------------------------------
// I2S dividers, in clk cycles per half-period
// ------------------------------

`define MIC_SCK_DIV      8                        // INMP441 bit clock
`define DAC_BCLK_DIV     8                        // DAC bit clock
`define DAC_MCLK_DIV     2                        // DAC master clock

`endif

//--- design/board_pkg.sv
`include "board_params.svh"

package board_pkg;

    // ------------------------------
    // Display and audio types
    // ------------------------------

    typedef logic [7:0]            seg_t;         // a in bit 7, dp in bit 0
    typedef logic [`W_DIGIT - 1:0] digit_sel_t;   // One-hot digit select
    typedef logic signed [23:0]    mic_sample_t;  // INMP441 word
    typedef logic signed [15:0]    sound_t;       // DAC word

    // Hex glyph for one nibble, decimal point off
    function automatic seg_t hex_to_seg(input logic [3:0] nibble);
        seg_t seg;
        case (nibble)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;  // Lower case b
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;  // Lower case d
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;  // F
        endcase
        return seg;
    endfunction

endpackage

//--- design/strobe_gen.sv
`timescale 1ns/1ps

module strobe_gen
#(
    parameter int period = 2
)
(
    input  logic clk,
    input  logic rst,
    output logic strobe
);

    localparam int                 w_cnt  = (period > 1) ? $clog2(period) : 1;
    localparam logic [w_cnt - 1:0] reload = w_cnt'(period - 1);

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt    <= reload;
            strobe <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt    <= reload;       // Start next period
            strobe <= 1'b1;
        end
        else
        begin
            cnt    <= cnt - 1'b1;
            strobe <= 1'b0;
        end
    end

    generate
        if (period > 1)
        begin : g_strobe_check
            assert property (@(posedge clk) disable iff (rst) strobe |=> !strobe)
                else $error("strobe_gen: strobe high for two cycles");
        end
    endgenerate

endmodule

//--- design/lab_top.sv
`timescale 1ns/1ps
`include "board_params.svh"

module lab_top
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           slow_tick,
    input  logic                           scan_tick,
    input  logic [`W_KEY - 1:0]            key,
    input  logic [`W_SW - 2:0]             sw,
    output logic [`W_LED - `W_DIGIT - 1:0] led,
    output board_pkg::seg_t                abcdefgh,
    output board_pkg::digit_sel_t          digit,
    input  board_pkg::mic_sample_t         mic,
    input  logic                           mic_valid,
    output board_pkg::sound_t              sound
);

    import board_pkg::*;

    localparam int w_cnt = 4 * `W_DIGIT;     // One nibble per digit

    logic [w_cnt - 1:0] cnt;
    digit_sel_t         digit_next;
    seg_t               seg_next;

    // ------------------------------
    // Hex counter
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (key[0])
            cnt <= '0;                       // Clear wins over the tick
        else if (slow_tick && sw[0])
            cnt <= cnt + 1'b1;
    end

    assign led = cnt[$bits(led) - 1:0];

    // ------------------------------
    // Digit scan
    // ------------------------------

    always_comb
    begin
        digit_next = scan_tick ? {digit[`W_DIGIT - 2:0], digit[`W_DIGIT - 1]} : digit;
        seg_next   = '0;
        for (int i = 0; i < `W_DIGIT; i++)
        begin
            if (digit_next[i])
                seg_next = hex_to_seg(cnt[4 * i +: 4]) | seg_t'(sw[i + 1]);
        end
    end

    // Select and pattern leave this block together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit    <= digit_sel_t'(1);
            abcdefgh <= '0;
        end
        else
        begin
            digit    <= digit_next;
            abcdefgh <= seg_next;
        end
    end

    // ------------------------------
    // Audio loop-back
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sound <= '0;
        else if (mic_valid)
            sound <= mic[23:8];              // Keep the top 16 bits
    end

    assert property (@(posedge clk) disable iff (rst) $onehot(digit))
        else $error("lab_top: digit select lost its one-hot state");

endmodule

//--- design/seven_seg_hold.sv
`timescale 1ns/1ps
`include "board_params.svh"

module seven_seg_hold
(
    input  logic                  clk,
    input  logic                  rst,
    input  board_pkg::seg_t       abcdefgh,
    input  board_pkg::digit_sel_t digit,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5,
    output logic [6:0]            hex6,
    output logic [6:0]            hex7,
    output logic [`W_DIGIT - 1:0] dp
);

    localparam int w_seg = $bits(abcdefgh);

    logic [w_seg - 1:0] hgfedcba;
    logic [6:0]         hex_q [`W_DIGIT];

    // Board wants segment a in bit 0
    always_comb
    begin
        for (int i = 0; i < w_seg; i++)
            hgfedcba[i] = abcdefgh[w_seg - 1 - i];
    end

    // ------------------------------
    // Sticky digit registers
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `W_DIGIT; i++)
                hex_q[i] <= '1;                      // Blank, segments are active low
            dp <= '0;
        end
        else
        begin
            for (int i = 0; i < `W_DIGIT; i++)
            begin
                if (digit[i])
                begin
                    hex_q[i] <= ~hgfedcba[6:0];
                    dp[i]    <= hgfedcba[w_seg - 1]; // dp stays active high
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];
    assign hex6 = hex_q[6];
    assign hex7 = hex_q[7];

endmodule

//--- design/i2s_mic_receiver.sv
`timescale 1ns/1ps
`include "board_params.svh"

module i2s_mic_receiver
(
    input  logic                   clk,
    input  logic                   rst,
    output logic                   sck,
    output logic                   ws,
    output logic                   lr,
    input  logic                   sd,
    output board_pkg::mic_sample_t value,
    output logic                   valid
);

    import board_pkg::*;

    localparam int w_div     = $clog2(`MIC_SCK_DIV + 1);
    localparam int w_word    = $bits(mic_sample_t);
    localparam int first_bit = 1;                      // One slot of delay after ws
    localparam int last_bit  = first_bit + w_word - 1;

    logic [w_div - 1:0] div_cnt;
    logic               sck_edge;
    logic [5:0]         slot;                          // sck period within the frame
    logic [5:0]         slot_next;
    logic               last_q;
    mic_sample_t        shift_q;

    assign sck_edge  = (div_cnt == w_div'(`MIC_SCK_DIV - 1));
    assign slot_next = slot + 6'd1;
    assign lr        = 1'b0;                           // Mic drives the left slot

    // ------------------------------
    // sck and ws generation
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            ws      <= 1'b0;
            slot    <= '0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
            if (sck)
            begin
                slot <= slot_next;                     // Falling edge of sck
                ws   <= slot_next[5];
            end
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // Sample sd as sck rises
    always_ff @(posedge clk)
    begin
        if (sck_edge && !sck && slot >= first_bit && slot <= last_bit)
            shift_q <= {shift_q[w_word - 2:0], sd};
        if (last_q)
            value <= shift_q;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            last_q <= 1'b0;
            valid  <= 1'b0;
        end
        else
        begin
            last_q <= sck_edge && !sck && (slot == last_bit);
            valid  <= last_q;
        end
    end

endmodule

//--- design/i2s_audio_out.sv
`timescale 1ns/1ps
`include "board_params.svh"

module i2s_audio_out
(
    input  logic              clk,
    input  logic              rst,
    input  board_pkg::sound_t data_in,
    output logic              mclk,
    output logic              bclk,
    output logic              lrclk,
    output logic              sdata
);

    import board_pkg::*;

    localparam int w_mdiv = $clog2(`DAC_MCLK_DIV + 1);
    localparam int w_bdiv = $clog2(`DAC_BCLK_DIV + 1);
    localparam int w_snd  = $bits(sound_t);

    logic [w_mdiv - 1:0] mdiv_cnt;
    logic [w_bdiv - 1:0] bdiv_cnt;
    logic                bclk_edge;
    logic                bclk_fall;
    logic [5:0]          slot;            // bclk period within the frame
    logic [5:0]          slot_next;
    sound_t              sample_q;        // Word for both channels of a frame
    sound_t              shift_q;

    assign bclk_edge = (bdiv_cnt == w_bdiv'(`DAC_BCLK_DIV - 1));
    assign bclk_fall = bclk_edge && bclk;
    assign slot_next = slot + 6'd1;

    // ------------------------------
    // Clock dividers
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mdiv_cnt <= '0;
            mclk     <= 1'b0;
        end
        else if (mdiv_cnt == w_mdiv'(`DAC_MCLK_DIV - 1))
        begin
            mdiv_cnt <= '0;
            mclk     <= ~mclk;
        end
        else
            mdiv_cnt <= mdiv_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bdiv_cnt <= '0;
            bclk     <= 1'b0;
        end
        else if (bclk_edge)
        begin
            bdiv_cnt <= '0;
            bclk     <= ~bclk;
        end
        else
            bdiv_cnt <= bdiv_cnt + 1'b1;
    end

    // ------------------------------
    // Frame and serializer
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slot     <= '0;
            lrclk    <= 1'b0;
            sdata    <= 1'b0;
            sample_q <= '0;
            shift_q  <= '0;
        end
        else if (bclk_fall)
        begin
            slot  <= slot_next;
            lrclk <= slot_next[5];
            if (slot_next[4:0] == 5'd0)
            begin
                sdata <= 1'b0;                     // MSB follows one bclk later
                if (!slot_next[5])
                begin
                    sample_q <= data_in;           // New word at lrclk fall
                    shift_q  <= data_in;
                end
                else
                    shift_q <= sample_q;           // Repeat for the right slot
            end
            else
            begin
                sdata   <= shift_q[w_snd - 1];
                shift_q <= shift_q << 1;           // Zeros fill the slot tail
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) $changed(lrclk) |-> !bclk)
        else $error("i2s_audio_out: lrclk moved while bclk high");

endmodule

//--- design/board_top.sv
`timescale 1ns/1ps
`include "board_params.svh"

module board_top
#(
    parameter int tick_cycles = `SLOW_TICK_CYCLES
)
(
    input  logic                clock_50,
    input  logic [`W_KEY - 1:0] key,        // Active low
    input  logic [`W_SW - 1:0]  sw,
    output logic [`W_LED - 1:0] ledr,
    output logic [6:0]          hex0,
    output logic [6:0]          hex1,
    output logic [6:0]          hex2,
    output logic [6:0]          hex3,
    output logic [6:0]          hex4,
    output logic [6:0]          hex5,
    output logic [6:0]          hex6,
    output logic [6:0]          hex7,
    output logic                mic_lr,
    output logic                mic_ws,
    output logic                mic_sck,
    input  logic                mic_sd,
    output logic                dac_mclk,
    output logic                dac_bclk,
    output logic                dac_lrclk,
    output logic                dac_sdata
);

    import board_pkg::*;

    localparam int w_lab_sw  = `W_SW - 1;           // Top switch is the reset
    localparam int w_lab_led = `W_LED - `W_DIGIT;   // Top LEDs carry dp

    logic                  clk;
    logic                  rst;
    logic [`W_KEY - 1:0]   lab_key;
    logic [w_lab_sw - 1:0] lab_sw;
    logic [w_lab_led - 1:0] lab_led;
    logic                  slow_tick;
    logic                  scan_tick;
    seg_t                  abcdefgh;
    digit_sel_t            digit;
    logic [`W_DIGIT - 1:0] dp;
    mic_sample_t           mic;
    logic                  mic_valid;
    sound_t                sound;

    assign clk     = clock_50;
    assign rst     = sw[w_lab_sw];
    assign lab_key = ~key;
    assign lab_sw  = sw[w_lab_sw - 1:0];
    assign ledr    = {dp, lab_led};

    strobe_gen #(.period(tick_cycles))  i_slow_tick (.clk(clk), .rst(rst), .strobe(slow_tick));
    strobe_gen #(.period(`SCAN_CYCLES)) i_scan_tick (.clk(clk), .rst(rst), .strobe(scan_tick));

    lab_top i_lab_top
    (
        .clk       (clk),       .rst      (rst),
        .slow_tick (slow_tick), .scan_tick(scan_tick),
        .key       (lab_key),   .sw       (lab_sw),
        .led       (lab_led),   .abcdefgh (abcdefgh),
        .digit     (digit),     .mic      (mic),
        .mic_valid (mic_valid), .sound    (sound)
    );

    seven_seg_hold i_seven_seg_hold
    (
        .clk  (clk),  .rst  (rst),  .abcdefgh (abcdefgh), .digit (digit),
        .hex0 (hex0), .hex1 (hex1), .hex2 (hex2), .hex3 (hex3),
        .hex4 (hex4), .hex5 (hex5), .hex6 (hex6), .hex7 (hex7),
        .dp   (dp)
    );

    i2s_mic_receiver i_mic
    (
        .clk (clk),    .rst (rst),    .sck   (mic_sck), .ws    (mic_ws),
        .lr  (mic_lr), .sd  (mic_sd), .value (mic),     .valid (mic_valid)
    );

    i2s_audio_out i_audio_out
    (
        .clk   (clk),       .rst   (rst),      .data_in (sound),
        .mclk  (dac_mclk),  .bclk  (dac_bclk), .lrclk   (dac_lrclk),
        .sdata (dac_sdata)
    );

endmodule

//--- tests/tb_board_top.sv
`timescale 1ns/1ps
`include "board_params.svh"

module tb_board_top;

    import board_pkg::*;

    localparam int tick_cycles     = 64;
    localparam int scan_wait       = `W_DIGIT * `SCAN_CYCLES + 4;       // One full scan plus pipeline
    localparam int frame_cycles    = 64 * 2 * `DAC_BCLK_DIV;
    localparam int watchdog_cycles = 40 * frame_cycles + 300 * tick_cycles;
    localparam int w_cnt_led       = `W_LED - `W_DIGIT;

    logic                clk;
    logic [`W_KEY - 1:0] key;
    logic [`W_SW - 1:0]  sw;
    logic [`W_LED - 1:0] ledr;
    logic [6:0]          hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
    logic                mic_lr, mic_ws, mic_sck, mic_sd;
    logic                dac_mclk, dac_bclk, dac_lrclk, dac_sdata;
    logic                dut_rst;
    logic [15:0]         lfsr_state = 16'd64773;

    // Microphone model state
    logic                sck_q      = 1'b0;
    logic                ws_q       = 1'b0;
    int                  mic_idx    = 0;
    mic_sample_t         mic_word   = '0;
    mic_sample_t         frame_word = '0;

    // DAC decoder state
    logic                dec_lr_q   = 1'b1;
    int                  dec_idx    = 0;
    sound_t              dec_shift  = '0;
    sound_t              dac_word   = '0;
    int                  dac_words  = 0;

    board_top #(.tick_cycles(tick_cycles)) dut0 (.clock_50(clk), .*);

    assign dut_rst = sw[`W_SW - 1];

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------
    // Error reporting and compares
    // ------------------------------

    task automatic report_error(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Board HEX output for one digit index
    function automatic logic [6:0] hex_digit(input int i);
        case (i)
            0:       return hex0;
            1:       return hex1;
            2:       return hex2;
            3:       return hex3;
            4:       return hex4;
            5:       return hex5;
            6:       return hex6;
            default: return hex7;
        endcase
    endfunction

    // Board digit from a glyph with a in bit 0 and segments active low
    function automatic logic [6:0] hex_pattern(input seg_t glyph);
        logic [6:0] h;
        for (int i = 0; i < 7; i++)
            h[i] = ~glyph[7 - i];
        return h;
    endfunction

    task automatic check_seg(input string name, input logic [6:0] got, input seg_t glyph);
        if (got !== hex_pattern(glyph))
            report_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                   $time, name, got, hex_pattern(glyph)));
    endtask

    task automatic check_led(input string name, input logic [`W_LED - 1:0] got,
                             input logic [`W_LED - 1:0] exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                   $time, name, got, exp));
    endtask

    task automatic check_sound(input string name, input sound_t got, input sound_t exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                                   $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                   $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_error($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                   $time, name, got, exp));
    endtask

    task automatic check_display(input logic [31:0] count);
        for (int i = 0; i < `W_DIGIT; i++)
            check_seg($sformatf("hex%0d", i), hex_digit(i), hex_to_seg(count[4 * i +: 4]));
    endtask

    // ------------------------------
    // Stimulus sources
    // ------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};        // x^16 + x^14 + x^13 + x^11
    endfunction

    task automatic draw_mic_word(output mic_sample_t w);
        w = '0;
        for (int i = 0; i < $bits(mic_sample_t); i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            w          = {w[$bits(mic_sample_t) - 2:0], lfsr_state[0]};
        end
    endtask

    // INMP441 model that changes sd one clock after each sck fall
    always @(posedge clk)
    begin
        if (dut_rst)
        begin
            sck_q   <= 1'b0;
            ws_q    <= 1'b0;
            mic_idx <= 0;
            mic_sd  <= 1'b0;
        end
        else
        begin
            sck_q <= mic_sck;
            ws_q  <= mic_ws;
            if (sck_q && !mic_sck)
            begin
                if (ws_q && !mic_ws)
                begin
                    mic_idx    <= 0;                            // Left slot starts
                    frame_word <= mic_word;
                    mic_sd     <= 1'b0;
                end
                else
                begin
                    mic_idx <= mic_idx + 1;
                    if (!mic_ws && mic_idx < 24)
                        mic_sd <= frame_word[23 - mic_idx];     // MSB in second slot
                    else
                        mic_sd <= 1'b0;
                end
            end
        end
    end

    // DAC decoder for the left slot only
    always @(posedge dac_bclk or posedge dut_rst)
    begin
        if (dut_rst)
        begin
            dec_lr_q  <= 1'b1;
            dec_idx   <= 0;
            dec_shift <= '0;
        end
        else
        begin
            dec_lr_q <= dac_lrclk;
            if (!dac_lrclk && dec_lr_q)
                dec_idx <= 0;                                   // Delay bit after lrclk fall
            else if (!dac_lrclk)
            begin
                dec_idx <= dec_idx + 1;
                if (dec_idx < 16)
                    dec_shift <= {dec_shift[14:0], dac_sdata};
                if (dec_idx == 15)
                begin
                    dac_word  <= {dec_shift[14:0], dac_sdata};
                    dac_words <= dac_words + 1;
                end
            end
        end
    end

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic reset_dut;
        sw[`W_SW - 1] <= 1'b1;
        repeat (8) @(posedge clk);
        sw[`W_SW - 1] <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < `W_DIGIT; i++)
            check_seg($sformatf("hex%0d", i), hex_digit(i), '0);  // Blank
        check_led("ledr", ledr, '0);
        check_bit("mic_sck", mic_sck, 1'b0);
        check_bit("mic_ws", mic_ws, 1'b0);
        check_bit("mic_lr", mic_lr, 1'b0);
        check_bit("dac_mclk", dac_mclk, 1'b0);
        check_bit("dac_bclk", dac_bclk, 1'b0);
        check_bit("dac_lrclk", dac_lrclk, 1'b0);
        check_bit("dac_sdata", dac_sdata, 1'b0);
    endtask

    task automatic count_and_show;
        logic [w_cnt_led - 1:0] last;
        logic [31:0]            count;
        int                     changes;
        sw[0] <= 1'b1;
        @(posedge clk);
        last    = ledr[w_cnt_led - 1:0];
        changes = 0;
        while (changes < 16)
        begin
            @(posedge clk);
            if (ledr[w_cnt_led - 1:0] != last)
            begin
                check_led("ledr", ledr, {{`W_DIGIT{1'b0}}, last + 1'b1});
                last    = ledr[w_cnt_led - 1:0];
                changes = changes + 1;
            end
        end
        sw[0] <= 1'b0;
        repeat (4) @(posedge clk);
        count = 32'(ledr[w_cnt_led - 1:0]);                     // Far below LED overflow
        repeat (scan_wait) @(posedge clk);
        check_display(count);
    endtask

    task automatic clear_counter;
        key[0] <= 1'b0;
        repeat (2) @(posedge clk);
        key[0] <= 1'b1;
        repeat (scan_wait) @(posedge clk);
        check_led("ledr", ledr, '0);
        check_display('0);
    endtask

    task automatic show_decimal_points;
        logic [`W_DIGIT - 1:0] pattern;
        pattern = 8'b1011_0010;
        sw[8:1] <= pattern;
        repeat (scan_wait) @(posedge clk);
        check_led("ledr", ledr, {pattern, {w_cnt_led{1'b0}}});
        check_display('0);
        sw[8:1] <= '0;
    endtask

    task automatic loop_back_audio;
        mic_sample_t w;
        int          start;
        for (int k = 0; k < 4; k++)
        begin
            draw_mic_word(w);
            mic_word <= w;
            start = dac_words;
            wait (dac_words >= start + 4);                     // Three frames and then the next word
            @(posedge clk);
            check_sound("dac word", dac_word, sound_t'(w[23:8]));
        end
    endtask

    // Bit clock rises between two frame clock toggles
    task automatic bits_per_half_frame(input logic use_dac, output int n);
        logic f_q, b_q, f, b;
        int   toggles;
        n       = 0;
        toggles = 0;
        @(posedge clk);
        f_q = use_dac ? dac_lrclk : mic_ws;
        b_q = use_dac ? dac_bclk : mic_sck;
        while (toggles < 2)
        begin
            @(posedge clk);
            f = use_dac ? dac_lrclk : mic_ws;
            b = use_dac ? dac_bclk : mic_sck;
            if (toggles == 1 && b && !b_q)
                n = n + 1;
            if (f != f_q)
                toggles = toggles + 1;
            f_q = f;
            b_q = b;
            check_bit("mic_lr", mic_lr, 1'b0);
        end
    endtask

    // Clock cycles between two dac_mclk toggles
    task automatic clocks_per_mclk_half(output int n);
        logic m_q;
        int   toggles;
        n       = 0;
        toggles = 0;
        @(posedge clk);
        m_q = dac_mclk;
        while (toggles < 2)
        begin
            @(posedge clk);
            if (toggles == 1)
                n = n + 1;
            if (dac_mclk != m_q)
                toggles = toggles + 1;
            m_q = dac_mclk;
        end
    endtask

    task automatic measure_i2s_clocks;
        int n;
        for (int i = 0; i < 2; i++)
        begin
            bits_per_half_frame(1'b1, n);
            check_count("dac_bclk periods per dac_lrclk half", n, 32);
            bits_per_half_frame(1'b0, n);
            check_count("mic_sck periods per mic_ws half", n, 32);
            clocks_per_mclk_half(n);
            check_count("clk cycles per dac_mclk half", n, `DAC_MCLK_DIV);
        end
    endtask

    initial
    begin
        key    = '1;                                            // Keys released
        sw     = '0;
        sw[`W_SW - 1] = 1'b1;
        mic_sd = 1'b0;
        reset_dut();
        count_and_show();
        clear_counter();
        show_decimal_points();
        loop_back_audio();
        measure_i2s_clocks();
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        report_error("Timeout: the watchdog expired before all tests finished");
    end

endmodule

//--- project.f
+incdir+design
design/board_pkg.sv
design/strobe_gen.sv
design/lab_top.sv
design/seven_seg_hold.sv
design/i2s_mic_receiver.sv
design/i2s_audio_out.sv
design/board_top.sv
tests/tb_board_top.sv
